// ==== compile.f ====
+incdir+.
cache_pkg.sv
byte_enable_ram.sv
tag_store.sv
line_data_store.sv
cache_control.sv
burst_cache.sv
burst_cache_checker.sv
burst_cache_monitor.sv
burst_cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the cache testbench
# the result is taken from the simulation log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module burst_cache_tb -f compile.f -o sim_burst_cache
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_burst_cache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Test completed successfully$" sim.log; then
  exit 0
fi

echo "pass message not found in sim.log"
exit 1

// ==== burst_cache_tb.sv ====
// ========================================
// cache testbench with clock, reset,
// burst RAM model and stimulus
// ========================================

`timescale 1ns/10ps

`include "cache_consts.svh"

module burst_cache_tb;

  import cache_pkg::*;

  // 1 + 8 + 9 + 2 + 2 directed accesses and 300 random ones
  localparam int num_txn    = 322;
  localparam int max_cycles = 200 * num_txn;
  localparam int rd_latency = 5;

  localparam tag_t     tag_a  = 11'h0a3;
  localparam tag_t     tag_b  = 11'h151;
  localparam tag_t     tag_c  = 11'h3f0;
  localparam line_ix_t line_a = 8'h2c;

  logic                           clk = 1'b0;
  logic                           rst;
  logic                           req;
  logic [`CACHE_ADDR_BITS-1:0]    address;
  logic [3:0]                     byte_en;
  logic [31:0]                    wr_data;
  logic [31:0]                    rd_data;
  logic                           rd_ready;
  logic                           busy;
  br_cmd_t                        br_cmd;
  logic                           br_cmd_en;
  logic [`CACHE_BR_ADDR_BITS-1:0] br_addr;
  logic [63:0]                    br_wr_data;
  logic [63:0]                    br_rd_data;
  logic                           br_rd_valid;

  logic                           hits_only;
  int                             errors;
  int                             read_checks;
  int                             beat_checks;
  int                             rd_bursts;
  int                             wr_bursts;
  logic [`CACHE_BR_ADDR_BITS-1:0] last_wr_addr;
  int                             scenario_errors;
  int                             reads_issued;
  int                             cycles;
  integer                         seed;

  // burst RAM beats by beat address
  // unwritten beats follow the fill pattern
  logic [63:0] ram [logic [`CACHE_BR_ADDR_BITS-1:0]];

  always #10 clk = ~clk;

  burst_cache i_burst_cache (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .address     (address),
    .byte_en     (byte_en),
    .wr_data     (wr_data),
    .rd_data     (rd_data),
    .rd_ready    (rd_ready),
    .busy        (busy),
    .br_cmd      (br_cmd),
    .br_cmd_en   (br_cmd_en),
    .br_addr     (br_addr),
    .br_wr_data  (br_wr_data),
    .br_rd_data  (br_rd_data),
    .br_rd_valid (br_rd_valid)
  );

  burst_cache_monitor i_monitor (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .address      (address),
    .byte_en      (byte_en),
    .wr_data      (wr_data),
    .rd_data      (rd_data),
    .rd_ready     (rd_ready),
    .busy         (busy),
    .br_cmd       (br_cmd),
    .br_cmd_en    (br_cmd_en),
    .br_addr      (br_addr),
    .br_wr_data   (br_wr_data),
    .hits_only    (hits_only),
    .errors       (errors),
    .read_checks  (read_checks),
    .beat_checks  (beat_checks),
    .rd_bursts    (rd_bursts),
    .wr_bursts    (wr_bursts),
    .last_wr_addr (last_wr_addr)
  );

  // word at a word address before anything was written to it
  function automatic logic [31:0] init_word(input logic [21:0] w);
    return {w, 10'h2b5};
  endfunction

  function automatic logic [63:0] ram_beat(input logic [`CACHE_BR_ADDR_BITS-1:0] ba);
    if (ram.exists(ba)) begin
      return ram[ba];
    end
    return {init_word({ba, 1'b1}), init_word({ba, 1'b0})};
  endfunction

  function automatic logic [`CACHE_ADDR_BITS-1:0] make_addr(input tag_t tag,
                                                           input line_ix_t line,
                                                           input col_ix_t col);
    return {tag, line, col, 2'b00};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      scenario_errors++;
      $display("ERROR %s: expected 0x%0h got 0x%0h", name, want, got);
    end
  endtask

  // one request held until the edge at which busy is low
  task automatic access(input logic [`CACHE_ADDR_BITS-1:0] addr, input logic [3:0] be,
                        input logic [31:0] data);
    @(negedge clk);
    req     = 1'b1;
    address = addr;
    byte_en = be;
    wr_data = data;
    if (be == 4'h0) begin
      reads_issued++;
    end
    #1;
    while (busy) begin
      @(negedge clk);
      #1;
    end
    @(posedge clk);
    @(negedge clk);
    req     = 1'b0;
    byte_en = 4'h0;
  endtask

  // burst RAM model stores write beats and answers reads with four back-to-back beats
  initial begin
    logic [`CACHE_BR_ADDR_BITS-1:0] rd_base;
    logic [`CACHE_BR_ADDR_BITS-1:0] wr_base;
    int                             rd_wait;
    int                             rd_left;
    int                             wr_left;
    br_rd_valid = 1'b0;
    br_rd_data  = '0;
    rd_base     = '0;
    wr_base     = '0;
    rd_wait     = 0;
    rd_left     = 0;
    wr_left     = 0;
    forever begin
      @(negedge clk);
      if (br_cmd_en && br_cmd == BR_WRITE) begin
        wr_base      = br_addr;
        ram[br_addr] = br_wr_data;
        wr_left      = 3;
      end else if (wr_left != 0) begin
        ram[wr_base + 21'(4 - wr_left)] = br_wr_data;
        wr_left--;
      end
      if (rd_left != 0) begin
        br_rd_valid = 1'b1;
        br_rd_data  = ram_beat(rd_base + 21'(4 - rd_left));
        rd_left--;
      end else begin
        br_rd_valid = 1'b0;
      end
      if (rd_wait != 0) begin
        rd_wait--;
        if (rd_wait == 0) begin
          rd_left = 4;
        end
      end
      if (br_cmd_en && br_cmd == BR_READ) begin
        rd_base = br_addr;
        rd_wait = rd_latency;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: run still active after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    logic [31:0] r;
    logic [3:0]  be;
    tag_t        tags [4];
    int          n;
    seed            = 92405;
    tags[0]         = tag_a;
    tags[1]         = tag_b;
    tags[2]         = tag_c;
    tags[3]         = 11'h7ff;
    rst             = 1'b1;
    req             = 1'b0;
    address         = '0;
    byte_en         = 4'h0;
    wr_data         = '0;
    hits_only       = 1'b0;
    scenario_errors = 0;
    reads_issued    = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // cold miss with one fill and no eviction
    access(make_addr(tag_a, line_a, 3'd3), 4'h0, '0);
    check_value("rd_bursts", rd_bursts, 1);
    check_value("wr_bursts", wr_bursts, 0);

    hits_only = 1'b1;
    for (int c = 0; c < `CACHE_COLS; c++) begin
      access(make_addr(tag_a, line_a, col_ix_t'(c)), 4'h0, '0);
    end
    access(make_addr(tag_a, line_a, 3'd2), 4'b0101, 32'hdead_beef);
    for (int c = 0; c < `CACHE_COLS; c++) begin
      access(make_addr(tag_a, line_a, col_ix_t'(c)), 4'h0, '0);
    end
    hits_only = 1'b0;

    // same line under another tag evicts the dirty victim first
    n = wr_bursts;
    access(make_addr(tag_b, line_a, 3'd5), 4'h0, '0);
    check_value("wr_bursts", wr_bursts, n + 1);
    check_value("last_wr_addr", 32'(last_wr_addr), 32'({tag_a, line_a, 2'b00}));
    access(make_addr(tag_a, line_a, 3'd2), 4'h0, '0);

    // write miss on a clean line
    n = wr_bursts;
    access(make_addr(tag_c, line_a, 3'd6), 4'b1010, 32'h1234_5678);
    check_value("wr_bursts", wr_bursts, n);
    access(make_addr(tag_c, line_a, 3'd6), 4'h0, '0);

    for (int i = 0; i < 300; i++) begin
      r  = $random(seed);
      be = 4'h0;
      if (r[9]) begin
        be = r[13:10];
        if (be == 4'h0) begin
          be = 4'hf;
        end
      end
      access(make_addr(tags[r[1:0]], 8'h40 + 8'(r[5:2]), r[8:6]), be, $random(seed));
    end

    @(negedge clk);
    // every read access completes with exactly one rd_ready
    check_value("read_checks", read_checks, reads_issued);
    $display("summary: %0d reads checked, %0d beats checked, %0d errors",
             read_checks, beat_checks, errors + scenario_errors);
    if (errors + scenario_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== burst_cache_monitor.sv ====
// ========================================
// cache monitor: golden memory, read data
// and eviction beat compare, counters
// ========================================

`timescale 1ns/10ps

`include "cache_consts.svh"

module burst_cache_monitor (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           req,
  input  logic [`CACHE_ADDR_BITS-1:0]    address,
  input  logic [3:0]                     byte_en,
  input  logic [31:0]                    wr_data,
  input  logic [31:0]                    rd_data,
  input  logic                           rd_ready,
  input  logic                           busy,
  input  cache_pkg::br_cmd_t             br_cmd,
  input  logic                           br_cmd_en,
  input  logic [`CACHE_BR_ADDR_BITS-1:0] br_addr,
  input  logic [63:0]                    br_wr_data,
  input  logic                           hits_only,
  output int                             errors,
  output int                             read_checks,
  output int                             beat_checks,
  output int                             rd_bursts,
  output int                             wr_bursts,
  output logic [`CACHE_BR_ADDR_BITS-1:0] last_wr_addr
);

  import cache_pkg::*;

  // words written so far, keyed by word address
  logic [31:0] golden [logic [21:0]];

  int                             wr_beat;
  logic [`CACHE_BR_ADDR_BITS-1:0] wr_base;

  // expected word at a byte address, unwritten words keep the RAM fill pattern
  function automatic logic [31:0] exp_word(input logic [`CACHE_ADDR_BITS-1:0] a);
    if (golden.exists(a[23:2])) begin
      return golden[a[23:2]];
    end
    return {a[23:2], 10'h2b5};
  endfunction

  always @(posedge clk) begin
    logic [31:0] want;
    logic [31:0] merged;
    logic [63:0] want_beat;
    if (rst) begin
      wr_beat     = 4;
      wr_base     = '0;
      errors      = 0;
      read_checks = 0;
      beat_checks = 0;
      rd_bursts   = 0;
      wr_bursts   = 0;
    end else begin
      if (rd_ready) begin
        want = exp_word(address);
        read_checks++;
        if (rd_data !== want) begin
          errors++;
          $display("ERROR rd_data: address 0x%06h expected 0x%08h got 0x%08h",
                   address, want, rd_data);
        end
      end
      // a write completes at this edge
      if (req && !busy && byte_en != 4'h0) begin
        merged = exp_word(address);
        for (int b = 0; b < 4; b++) begin
          if (byte_en[b]) begin
            merged[8*b +: 8] = wr_data[8*b +: 8];
          end
        end
        golden[address[23:2]] = merged;
      end
      if (br_cmd_en && hits_only) begin
        errors++;
        $display("burst command at beat address 0x%06h while every access should hit",
                 br_addr);
      end
      if (br_cmd_en && br_cmd == BR_WRITE) begin
        wr_bursts++;
        wr_base      = br_addr;
        last_wr_addr = br_addr;
        wr_beat      = 0;
      end else if (br_cmd_en) begin
        rd_bursts++;
      end
      // beat 0 rides with the command, the rest follow one per cycle
      if (wr_beat < 4) begin
        want_beat = {exp_word({wr_base + 21'(wr_beat), 3'b100}),
                     exp_word({wr_base + 21'(wr_beat), 3'b000})};
        beat_checks++;
        if (br_wr_data !== want_beat) begin
          errors++;
          $display("ERROR br_wr_data: beat 0x%06h expected 0x%016h got 0x%016h",
                   wr_base + 21'(wr_beat), want_beat, br_wr_data);
        end
        wr_beat++;
      end
    end
  end

endmodule

// ==== burst_cache_checker.sv ====
// ========================================
// bound assertions: command spacing,
// write burst length, busy without req
// ========================================

`timescale 1ns/10ps

`include "cache_consts.svh"

module burst_cache_checker (
  input  logic               clk,
  input  logic               rst,
  input  logic               req,
  input  logic               busy,
  input  cache_pkg::br_cmd_t br_cmd,
  input  logic               br_cmd_en
);

  import cache_pkg::*;

  // cycles since the last command, saturating
  logic [7:0] since_cmd;
  logic       wr_cmd;

  assign wr_cmd = br_cmd_en && (br_cmd == BR_WRITE);

  always_ff @(posedge clk) begin
    if (rst) begin
      since_cmd <= 8'hff;
    end else if (br_cmd_en) begin
      since_cmd <= 8'd1;
    end else if (since_cmd != 8'hff) begin
      since_cmd <= since_cmd + 8'd1;
    end
  end

  cmd_spacing: assert property (@(posedge clk) disable iff (rst)
    br_cmd_en |-> (since_cmd > 8'(`CACHE_CMD_DELAY)))
    else $error("burst command only %0d cycles after the previous one", since_cmd);

  // beats 1 to 3 of a write burst own the bus
  write_burst_quiet: assert property (@(posedge clk) disable iff (rst)
    br_cmd_en |-> (!$past(wr_cmd, 1) && !$past(wr_cmd, 2) && !$past(wr_cmd, 3)))
    else $error("burst command inside the beats of a write burst");

  busy_needs_req: assert property (@(posedge clk) disable iff (rst) !req |-> !busy)
    else $error("busy high without a request");

endmodule

bind burst_cache burst_cache_checker i_checker (
  .clk       (clk),
  .rst       (rst),
  .req       (req),
  .busy      (busy),
  .br_cmd    (br_cmd),
  .br_cmd_en (br_cmd_en)
);

// ==== burst_cache.sv ====
// ========================================
// direct-mapped write-back cache top
// control, tag store and line data store
// ========================================

`timescale 1ns/10ps

`include "cache_consts.svh"

module burst_cache (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           req,
  input  logic [`CACHE_ADDR_BITS-1:0]    address,
  input  logic [3:0]                     byte_en,
  input  logic [31:0]                    wr_data,
  output logic [31:0]                    rd_data,
  output logic                           rd_ready,
  output logic                           busy,
  output cache_pkg::br_cmd_t             br_cmd,
  output logic                           br_cmd_en,
  output logic [`CACHE_BR_ADDR_BITS-1:0] br_addr,
  output logic [63:0]                    br_wr_data,
  input  logic [63:0]                    br_rd_data,
  input  logic                           br_rd_valid
);

  import cache_pkg::*;

  // |tag|line|col|byte|
  line_ix_t line_ix;
  col_ix_t  col_ix;
  tag_t     tag;

  logic        hit;
  logic        dirty;
  tag_t        victim_tag;
  logic [3:0]  cpu_we;
  logic        tag_we;
  logic        tag_set_dirty;
  logic        fill_we;
  logic [1:0]  fill_beat;
  logic [1:0]  evict_beat;
  logic [63:0] evict_data;

  assign col_ix  = address[`CACHE_COL_BITS + `CACHE_BYTE_BITS - 1 -: `CACHE_COL_BITS];
  assign line_ix = address[`CACHE_LINE_BITS + `CACHE_COL_BITS + `CACHE_BYTE_BITS - 1 -:
                           `CACHE_LINE_BITS];
  assign tag     = address[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS];

  // zero byte enables mean a read
  assign rd_ready = req && !busy && (byte_en == 4'h0);

  cache_control i_cache_control (
    .clk           (clk),
    .rst           (rst),
    .req           (req),
    .byte_en       (byte_en),
    .address       (address),
    .hit           (hit),
    .dirty         (dirty),
    .victim_tag    (victim_tag),
    .evict_data    (evict_data),
    .br_rd_valid   (br_rd_valid),
    .busy          (busy),
    .cpu_we        (cpu_we),
    .tag_we        (tag_we),
    .tag_set_dirty (tag_set_dirty),
    .fill_we       (fill_we),
    .fill_beat     (fill_beat),
    .evict_beat    (evict_beat),
    .br_cmd        (br_cmd),
    .br_cmd_en     (br_cmd_en),
    .br_addr       (br_addr),
    .br_wr_data    (br_wr_data)
  );

  tag_store i_tag_store (
    .clk           (clk),
    .rst           (rst),
    .line_ix       (line_ix),
    .tag           (tag),
    .tag_we        (tag_we),
    .tag_set_dirty (tag_set_dirty),
    .hit           (hit),
    .dirty         (dirty),
    .victim_tag    (victim_tag)
  );

  line_data_store i_line_data_store (
    .clk        (clk),
    .line_ix    (line_ix),
    .col_ix     (col_ix),
    .cpu_we     (cpu_we),
    .wr_data    (wr_data),
    .fill_we    (fill_we),
    .fill_beat  (fill_beat),
    .br_rd_data (br_rd_data),
    .evict_beat (evict_beat),
    .rd_data    (rd_data),
    .evict_data (evict_data)
  );

endmodule

// ==== cache_control.sv ====
// ========================================
// miss FSM, eviction and fill sequencing
// command spacing counter
// burst RAM command and write data outputs
// ========================================

`timescale 1ns/10ps

`include "cache_consts.svh"

module cache_control (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           req,
  input  logic [3:0]                     byte_en,
  input  logic [`CACHE_ADDR_BITS-1:0]    address,
  input  logic                           hit,
  input  logic                           dirty,
  input  cache_pkg::tag_t                victim_tag,
  input  logic [63:0]                    evict_data,
  input  logic                           br_rd_valid,
  output logic                           busy,
  output logic [3:0]                     cpu_we,
  output logic                           tag_we,
  output logic                           tag_set_dirty,
  output logic                           fill_we,
  output logic [1:0]                     fill_beat,
  output logic [1:0]                     evict_beat,
  output cache_pkg::br_cmd_t             br_cmd,
  output logic                           br_cmd_en,
  output logic [`CACHE_BR_ADDR_BITS-1:0] br_addr,
  output logic [63:0]                    br_wr_data
);

  import cache_pkg::*;

  localparam int cnt_bits = $clog2(`CACHE_CMD_DELAY + 1);

  cache_state_t       state;
  logic [cnt_bits-1:0] spacing_cnt;
  logic [1:0]          beat;

  logic                           idle_miss;
  logic                           issue_write;
  logic                           issue_read;
  logic [`CACHE_LINE_BITS-1:0]    line_field;
  logic [`CACHE_BR_ADDR_BITS-1:0] fill_addr;
  logic [`CACHE_BR_ADDR_BITS-1:0] victim_addr;

  // burst addresses point at beat 0 of a line
  assign line_field = address[`CACHE_LINE_BITS + `CACHE_COL_BITS + `CACHE_BYTE_BITS - 1 -:
                              `CACHE_LINE_BITS];
  assign fill_addr = {address[`CACHE_ADDR_BITS-1:`CACHE_COL_BITS + `CACHE_BYTE_BITS],
                      {$clog2(`CACHE_BEATS){1'b0}}};
  assign victim_addr = {victim_tag, line_field, {$clog2(`CACHE_BEATS){1'b0}}};

  // a miss waits in IDLE until the spacing counter has run out
  assign idle_miss   = (state == IDLE) && req && !hit && (spacing_cnt == '0);
  assign issue_write = idle_miss && dirty;
  assign issue_read  = (idle_miss && !dirty) || ((state == EVICT_WAIT) && (spacing_cnt == '0));

  // requester side, hits are served in IDLE only
  assign busy          = req && !((state == IDLE) && hit);
  assign cpu_we        = ((state == IDLE) && req && hit) ? byte_en : 4'h0;
  assign tag_set_dirty = (state == IDLE) && req && hit && (byte_en != 4'h0);
  assign tag_we        = tag_set_dirty || (state == TAG_UPDATE);

  // beats go straight into the line in their valid cycle
  assign fill_we    = br_rd_valid && ((state == FILL_WAIT) || (state == FILL_BEAT));
  assign fill_beat  = beat;
  assign evict_beat = beat;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      spacing_cnt <= '0;
      beat        <= 2'd0;
      br_cmd_en   <= 1'b0;
    end else begin
      br_cmd_en <= 1'b0;

      if (issue_write || issue_read) begin
        br_cmd_en   <= 1'b1;
        spacing_cnt <= cnt_bits'(`CACHE_CMD_DELAY);
      end else if (spacing_cnt != '0) begin
        spacing_cnt <= spacing_cnt - 1'b1;
      end

      case (state)
        IDLE: begin
          if (issue_write) begin
            // beat 0 leaves with the command
            beat  <= 2'd1;
            state <= EVICT_BEAT;
          end else if (issue_read) begin
            state <= FILL_WAIT;
          end
        end

        EVICT_BEAT: begin
          beat <= beat + 2'd1;
          if (beat == 2'd3) begin
            state <= EVICT_WAIT;
          end
        end

        EVICT_WAIT: begin
          if (issue_read) begin
            state <= FILL_WAIT;
          end
        end

        FILL_WAIT: begin
          if (br_rd_valid) begin
            beat  <= 2'd1;
            state <= FILL_BEAT;
          end
        end

        FILL_BEAT: begin
          if (br_rd_valid) begin
            beat <= beat + 2'd1;
            if (beat == 2'd3) begin
              state <= TAG_UPDATE;
            end
          end
        end

        TAG_UPDATE: begin
          state <= IDLE;
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // command payload, only meaningful alongside br_cmd_en or the beats after it
  always_ff @(posedge clk) begin
    if (issue_write) begin
      br_cmd  <= BR_WRITE;
      br_addr <= victim_addr;
    end else if (issue_read) begin
      br_cmd  <= BR_READ;
      br_addr <= fill_addr;
    end
    if (issue_write || (state == EVICT_BEAT)) begin
      br_wr_data <= evict_data;
    end
  end

endmodule

// ==== line_data_store.sv ====
// ========================================
// cache line data, one memory per column
// requester and fill write paths
// word read and eviction beat read
// ========================================

`timescale 1ns/10ps

`include "cache_consts.svh"

module line_data_store (
  input  logic                clk,
  input  cache_pkg::line_ix_t line_ix,
  input  cache_pkg::col_ix_t  col_ix,
  input  logic [3:0]          cpu_we,
  input  logic [31:0]         wr_data,
  input  logic                fill_we,
  input  logic [1:0]          fill_beat,
  input  logic [63:0]         br_rd_data,
  input  logic [1:0]          evict_beat,
  output logic [31:0]         rd_data,
  output logic [63:0]         evict_data
);

  logic [31:0] col_rdata [`CACHE_COLS];

  for (genvar c = 0; c < `CACHE_COLS; c++) begin : g_col
    logic        fill_sel;
    logic [3:0]  col_we;
    logic [31:0] col_wdata;

    // beat n carries columns 2n (low half) and 2n+1 (high half)
    assign fill_sel = fill_we && (fill_beat == 2'(c / 2));

    // fill wins, the requester is held busy during a fill anyway
    assign col_we = fill_sel ? 4'hf :
                    (col_ix == `CACHE_COL_BITS'(c)) ? cpu_we : 4'h0;

    assign col_wdata = fill_sel ? br_rd_data[32*(c%2) +: 32] : wr_data;

    byte_enable_ram i_ram (
      .clk   (clk),
      .we    (col_we),
      .waddr (line_ix),
      .wdata (col_wdata),
      .raddr (line_ix),
      .rdata (col_rdata[c])
    );
  end

  assign rd_data = col_rdata[col_ix];

  // same column pairing as the fill
  assign evict_data = {col_rdata[{evict_beat, 1'b1}], col_rdata[{evict_beat, 1'b0}]};

endmodule

// ==== tag_store.sv ====
// ========================================
// tag memory with valid and dirty flags
// hit compare for the addressed line
// ========================================

`timescale 1ns/10ps

`include "cache_consts.svh"

module tag_store (
  input  logic                clk,
  input  logic                rst,
  input  cache_pkg::line_ix_t line_ix,
  input  cache_pkg::tag_t     tag,
  input  logic                tag_we,
  input  logic                tag_set_dirty,
  output logic                hit,
  output logic                dirty,
  output cache_pkg::tag_t     victim_tag
);

  import cache_pkg::*;

  tag_t tag_mem [(1 << `CACHE_LINE_BITS)];

  // one flag bit per line
  logic [(1 << `CACHE_LINE_BITS)-1:0] valid_q;
  logic [(1 << `CACHE_LINE_BITS)-1:0] dirty_q;

  always_ff @(posedge clk) begin
    if (tag_we) begin
      tag_mem[line_ix] <= tag;
    end
  end

  // a write hit sets dirty, a completed fill clears it
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (tag_we) begin
      valid_q[line_ix] <= 1'b1;
      dirty_q[line_ix] <= tag_set_dirty;
    end
  end

  // stored tag doubles as the eviction address
  assign victim_tag = tag_mem[line_ix];
  assign hit        = valid_q[line_ix] && (victim_tag == tag);
  assign dirty      = dirty_q[line_ix];

endmodule

// ==== byte_enable_ram.sv ====
// ========================================
// 32-bit word memory, one entry per line
// byte write enables, async read
// ========================================

`timescale 1ns/10ps

`include "cache_consts.svh"

module byte_enable_ram (
  input  logic                clk,
  input  logic [3:0]          we,
  input  cache_pkg::line_ix_t waddr,
  input  logic [31:0]         wdata,
  input  cache_pkg::line_ix_t raddr,
  output logic [31:0]         rdata
);

  logic [31:0] mem [(1 << `CACHE_LINE_BITS)];

  // each enabled byte lane is written on its own
  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (we[b]) begin
        mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

  assign rdata = mem[raddr];

endmodule

// ==== cache_pkg.sv ====
// ========================================
// controller state and burst command enums
// address field types
// ========================================

`include "cache_consts.svh"

package cache_pkg;

  typedef enum logic [2:0] {
    IDLE,
    EVICT_BEAT,
    EVICT_WAIT,
    FILL_WAIT,
    FILL_BEAT,
    TAG_UPDATE
  } cache_state_t;

  // matches the burst RAM encoding, 0 read and 1 write
  typedef enum logic {
    BR_READ  = 1'b0,
    BR_WRITE = 1'b1
  } br_cmd_t;

  typedef logic [`CACHE_TAG_BITS-1:0] tag_t;
  typedef logic [`CACHE_LINE_BITS-1:0] line_ix_t;
  typedef logic [`CACHE_COL_BITS-1:0] col_ix_t;

endpackage

// ==== cache_consts.svh ====
// ========================================
// address field widths, line geometry,
// burst length and command spacing
// ========================================

`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// byte address seen by the requester
`define CACHE_ADDR_BITS 24

// |tag|line|col|byte|
`define CACHE_BYTE_BITS 2
`define CACHE_COL_BITS 3
`define CACHE_LINE_BITS 8
`define CACHE_TAG_BITS 11

// eight 32-bit words per line, moved as four 64-bit beats
`define CACHE_COLS 8
`define CACHE_BEATS 4

// burst RAM address counts 8-byte units
`define CACHE_BR_ADDR_BITS 21
`define CACHE_CMD_DELAY 13

`endif
